// File: hw/soc_bus_macros.svh
`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// CPU side of the data bus.
`define ADDRESS_WIDTH        32
`define WORD_WIDTH           32
`define BYTE_LANES           4
`define PREFIX_WIDTH         4

// Top address nibble of each target.
`define PREFIX_BOOTROM       4'h0
`define PREFIX_RAM           4'h1
`define PREFIX_TIMER         4'h2
`define PREFIX_GPIO          4'h3

// Word address handed to every target, wide enough for the RAM.
`define TARGET_ADDRESS_WIDTH 8
`define RAM_ADDRESS_WIDTH    8
`define BOOTROM_ADDRESS_WIDTH 6
`define TIMER_ADDRESS_WIDTH  2
`define GPIO_ADDRESS_WIDTH   2

// Timer registers.
`define TIMER_REG_COUNT      2'd0
`define TIMER_REG_COMPARE    2'd1
`define TIMER_REG_STATUS     2'd2

// GPIO registers.
`define GPIO_REG_OUT         2'd0
`define GPIO_REG_IN          2'd1
`define GPIO_REG_IRQ_EN      2'd2

`define GPIO_WIDTH           16 // Pins.

`endif

// File: hw/soc_bus_pkg.sv
`default_nettype none

`include "soc_bus_macros.svh"

package soc_bus_pkg;

    typedef logic [`WORD_WIDTH-1:0]           word_t;
    typedef logic [`ADDRESS_WIDTH-1:0]        address_t;
    typedef logic [`BYTE_LANES-1:0]           byte_mask_t;
    typedef logic [`GPIO_WIDTH-1:0]           gpio_t;
    typedef logic [`TARGET_ADDRESS_WIDTH-1:0] target_address_t;

    // Request as issued by the CPU.
    typedef struct packed {
        logic       read;
        logic       write;
        address_t   address; // Byte address.
        word_t      data_wr;
        byte_mask_t mask;
    } bus_req_t;

    typedef struct packed {
        word_t data_rd;
        logic  stall;
    } bus_rsp_t;

    // Request after decoding, with a word address.
    typedef struct packed {
        logic            read;
        logic            write;
        target_address_t address;
        word_t           data_wr;
        byte_mask_t      mask;
    } target_req_t;

endpackage

`default_nettype wire

// File: hw/data_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module data_bus (
    input  logic                     clk,
    input  soc_bus_pkg::bus_req_t    cpu_req,
    output soc_bus_pkg::bus_rsp_t    cpu_rsp,
    output logic                     interrupt,
    output soc_bus_pkg::target_req_t rom_req,
    input  soc_bus_pkg::bus_rsp_t    rom_rsp,
    output soc_bus_pkg::target_req_t ram_req,
    input  soc_bus_pkg::bus_rsp_t    ram_rsp,
    output soc_bus_pkg::target_req_t timer_req,
    input  soc_bus_pkg::bus_rsp_t    timer_rsp,
    output soc_bus_pkg::target_req_t gpio_req,
    input  soc_bus_pkg::bus_rsp_t    gpio_rsp,
    input  logic                     timer_irq,
    input  logic                     gpio_irq
);

    logic [`PREFIX_WIDTH-1:0]  prefix;
    soc_bus_pkg::target_req_t  fanout;

    assign prefix    = cpu_req.address[`ADDRESS_WIDTH-1 -: `PREFIX_WIDTH];
    assign interrupt = timer_irq | gpio_irq;

    // Shared fields, strobes stay low until a target is selected.
    assign fanout.read    = 1'b0;
    assign fanout.write   = 1'b0;
    assign fanout.address = cpu_req.address[2 +: `TARGET_ADDRESS_WIDTH];
    assign fanout.data_wr = cpu_req.data_wr;
    assign fanout.mask    = cpu_req.mask;

    always_comb begin
        rom_req   = fanout;
        ram_req   = fanout;
        timer_req = fanout;
        gpio_req  = fanout;

        cpu_rsp.data_rd = '0; // Unmapped reads return zero.
        cpu_rsp.stall   = 1'b0;

        unique casez (prefix)
            `PREFIX_BOOTROM: begin
                rom_req.read = cpu_req.read; // Read-only target.
                cpu_rsp      = rom_rsp;
            end

            `PREFIX_RAM: begin
                ram_req.read  = cpu_req.read;
                ram_req.write = cpu_req.write;
                cpu_rsp       = ram_rsp;
            end

            `PREFIX_TIMER: begin
                timer_req.read  = cpu_req.read;
                timer_req.write = cpu_req.write;
                cpu_rsp         = timer_rsp;
            end

            `PREFIX_GPIO: begin
                gpio_req.read  = cpu_req.read;
                gpio_req.write = cpu_req.write;
                cpu_rsp        = gpio_rsp;
            end

            default: begin
                cpu_rsp.data_rd = '0;
                cpu_rsp.stall   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/bus_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module bus_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  soc_bus_pkg::target_req_t req,
    output soc_bus_pkg::bus_rsp_t    rsp
);

    localparam int DEPTH = 1 << `RAM_ADDRESS_WIDTH;

    soc_bus_pkg::word_t             mem [DEPTH];
    soc_bus_pkg::word_t             rd_data;
    logic [`RAM_ADDRESS_WIDTH-1:0]  index;
    logic                           pending;

    assign index = req.address[`RAM_ADDRESS_WIDTH-1:0];

    // Set for the second cycle of a read.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= req.read & ~pending;
        end
    end

    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int b = 0; b < `BYTE_LANES; b++) begin
                if (req.mask[b]) begin
                    mem[index][8*b +: 8] <= req.data_wr[8*b +: 8];
                end
            end
        end
        if (req.read && !pending) begin
            rd_data <= mem[index];
        end
    end

    assign rsp.data_rd = rd_data;
    assign rsp.stall   = req.read & ~pending; // First read cycle only.

endmodule

`default_nettype wire

// File: hw/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module boot_rom (
    input  soc_bus_pkg::target_req_t req,
    output soc_bus_pkg::bus_rsp_t    rsp
);

    localparam int WORDS = 1 << `BOOTROM_ADDRESS_WIDTH;

    typedef soc_bus_pkg::word_t rom_table_t [WORDS];

    // Entry i is B0, then i, then i squared in the low half.
    function automatic rom_table_t build_table();
        rom_table_t t;
        for (int i = 0; i < WORDS; i++) begin
            t[i] = {8'hB0, 8'(i), 16'(i * i)};
        end
        return t;
    endfunction

    localparam rom_table_t ROM_TABLE = build_table();

    logic [`BOOTROM_ADDRESS_WIDTH-1:0] index;

    assign index = req.address[`BOOTROM_ADDRESS_WIDTH-1:0];

    assign rsp.data_rd = req.read ? ROM_TABLE[index] : '0;
    assign rsp.stall   = 1'b0;

endmodule

`default_nettype wire

// File: hw/bus_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module bus_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  soc_bus_pkg::target_req_t req,
    output soc_bus_pkg::bus_rsp_t    rsp,
    output logic                     irq
);

    soc_bus_pkg::word_t               count;
    soc_bus_pkg::word_t               compare;
    logic                             enable;
    logic                             pending;
    logic                             hit;
    logic [`TIMER_ADDRESS_WIDTH-1:0]  reg_sel;

    assign reg_sel = req.address[`TIMER_ADDRESS_WIDTH-1:0];
    assign hit     = enable && (compare != '0) && (count == compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            compare <= '0;
            enable  <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (hit) begin
                count   <= '0;
                pending <= 1'b1;
            end else if (enable) begin
                count <= count + 1'b1;
            end

            // CPU writes take priority over the counter.
            if (req.write) begin
                case (reg_sel)
                    `TIMER_REG_COUNT:   count   <= req.data_wr;
                    `TIMER_REG_COMPARE: compare <= req.data_wr;
                    `TIMER_REG_STATUS: begin
                        enable <= req.data_wr[0];
                        if (req.data_wr[1]) begin
                            pending <= 1'b0; // Write one to clear.
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rsp.data_rd = '0;
        rsp.stall   = 1'b0;
        if (req.read) begin
            case (reg_sel)
                `TIMER_REG_COUNT:   rsp.data_rd = count;
                `TIMER_REG_COMPARE: rsp.data_rd = compare;
                `TIMER_REG_STATUS:  rsp.data_rd = {30'b0, pending, enable};
                default:            rsp.data_rd = '0;
            endcase
        end
    end

    assign irq = pending;

endmodule

`default_nettype wire

// File: hw/bus_gpio.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module bus_gpio (
    input  logic                     clk,
    input  logic                     rst,
    input  soc_bus_pkg::target_req_t req,
    output soc_bus_pkg::bus_rsp_t    rsp,
    output logic                     irq,
    input  soc_bus_pkg::gpio_t       gpio_in,
    output soc_bus_pkg::gpio_t       gpio_out
);

    soc_bus_pkg::gpio_t              out_reg;
    soc_bus_pkg::gpio_t              irq_en;
    logic [`GPIO_ADDRESS_WIDTH-1:0]  reg_sel;

    assign reg_sel = req.address[`GPIO_ADDRESS_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_reg <= '0;
            irq_en  <= '0;
        end else if (req.write) begin
            case (reg_sel)
                `GPIO_REG_OUT: begin
                    for (int b = 0; b < `GPIO_WIDTH / 8; b++) begin
                        if (req.mask[b]) begin
                            out_reg[8*b +: 8] <= req.data_wr[8*b +: 8];
                        end
                    end
                end
                `GPIO_REG_IRQ_EN: irq_en <= req.data_wr[`GPIO_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rsp.data_rd = '0;
        rsp.stall   = 1'b0;
        if (req.read) begin
            case (reg_sel)
                `GPIO_REG_OUT:    rsp.data_rd = soc_bus_pkg::word_t'(out_reg);
                `GPIO_REG_IN:     rsp.data_rd = soc_bus_pkg::word_t'(gpio_in);
                `GPIO_REG_IRQ_EN: rsp.data_rd = soc_bus_pkg::word_t'(irq_en);
                default:          rsp.data_rd = '0;
            endcase
        end
    end

    assign irq      = |(gpio_in & irq_en); // Level, not latched.
    assign gpio_out = out_reg;

endmodule

`default_nettype wire

// File: hw/bus_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem (
    input  logic                  clk,
    input  logic                  rst,
    input  soc_bus_pkg::bus_req_t req,
    output soc_bus_pkg::bus_rsp_t rsp,
    output logic                  interrupt,
    input  soc_bus_pkg::gpio_t    gpio_in,
    output soc_bus_pkg::gpio_t    gpio_out
);

    soc_bus_pkg::target_req_t rom_req;
    soc_bus_pkg::target_req_t ram_req;
    soc_bus_pkg::target_req_t timer_req;
    soc_bus_pkg::target_req_t gpio_req;
    soc_bus_pkg::bus_rsp_t    rom_rsp;
    soc_bus_pkg::bus_rsp_t    ram_rsp;
    soc_bus_pkg::bus_rsp_t    timer_rsp;
    soc_bus_pkg::bus_rsp_t    gpio_rsp;
    logic                     timer_irq;
    logic                     gpio_irq;

    data_bus i_data_bus (
        .clk       (clk),
        .cpu_req   (req),
        .cpu_rsp   (rsp),
        .interrupt (interrupt),
        .rom_req   (rom_req),
        .rom_rsp   (rom_rsp),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp),
        .timer_req (timer_req),
        .timer_rsp (timer_rsp),
        .gpio_req  (gpio_req),
        .gpio_rsp  (gpio_rsp),
        .timer_irq (timer_irq),
        .gpio_irq  (gpio_irq)
    );

    boot_rom i_boot_rom (
        .req (rom_req),
        .rsp (rom_rsp)
    );

    bus_ram i_bus_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

    bus_timer i_bus_timer (
        .clk (clk),
        .rst (rst),
        .req (timer_req),
        .rsp (timer_rsp),
        .irq (timer_irq)
    );

    bus_gpio i_bus_gpio (
        .clk      (clk),
        .rst      (rst),
        .req      (gpio_req),
        .rsp      (gpio_rsp),
        .irq      (gpio_irq),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

`default_nettype wire

// File: verif/bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bus_checker (
    input logic                     clk,
    input soc_bus_pkg::bus_req_t    cpu_req,
    input soc_bus_pkg::bus_rsp_t    cpu_rsp,
    input soc_bus_pkg::target_req_t rom_req,
    input soc_bus_pkg::target_req_t ram_req,
    input soc_bus_pkg::target_req_t timer_req,
    input soc_bus_pkg::target_req_t gpio_req
);

    int         failures = 0;
    logic [3:0] strobes;

    assign strobes = {rom_req.read | rom_req.write, ram_req.read | ram_req.write,
                      timer_req.read | timer_req.write, gpio_req.read | gpio_req.write};

    one_target: assert property (@(posedge clk) $onehot0(strobes))
        else begin
            failures++;
            $error("More than one target strobe is active");
        end

    rom_read_only: assert property (@(posedge clk) !rom_req.write)
        else begin
            failures++;
            $error("Write strobe reached the boot ROM");
        end

    // The CPU keeps a stalled request unchanged.
    held_request: assert property (@(posedge clk)
        (cpu_req.read || cpu_req.write) && cpu_rsp.stall |=> $stable(cpu_req))
        else begin
            failures++;
            $error("CPU request changed while stall was high");
        end

endmodule

bind data_bus bus_checker i_bus_checker (
    .clk       (clk),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .rom_req   (rom_req),
    .ram_req   (ram_req),
    .timer_req (timer_req),
    .gpio_req  (gpio_req)
);

`default_nettype wire

// File: verif/bus_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module bus_monitor (
    input  logic                  clk,
    input  logic                  rst,
    input  soc_bus_pkg::bus_req_t req,
    input  soc_bus_pkg::bus_rsp_t rsp,
    input  logic                  interrupt,
    input  soc_bus_pkg::gpio_t    gpio_in,
    input  soc_bus_pkg::gpio_t    gpio_out,
    input  soc_bus_pkg::word_t    expected,
    input  logic                  exp_irq,
    input  logic                  check,
    output int                    errors,
    output int                    checks
);

    soc_bus_pkg::word_t ram_model [1 << `RAM_ADDRESS_WIDTH];
    soc_bus_pkg::gpio_t out_model;
    soc_bus_pkg::gpio_t en_model;
    soc_bus_pkg::word_t compare_model;
    int                 stall_cycles;

    function automatic soc_bus_pkg::word_t merge_lanes(input soc_bus_pkg::word_t old_word,
                                                       input soc_bus_pkg::word_t new_word,
                                                       input soc_bus_pkg::byte_mask_t mask);
        soc_bus_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < `BYTE_LANES; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic soc_bus_pkg::word_t model_read(input logic [`PREFIX_WIDTH-1:0] prefix,
                                                      input logic [7:0] word);
        int idx;
        idx = word[`BOOTROM_ADDRESS_WIDTH-1:0];
        case (prefix)
            `PREFIX_BOOTROM: return 32'hB000_0000 | (idx << 16) | ((idx * idx) % 65536);
            `PREFIX_RAM:     return ram_model[word];
            `PREFIX_TIMER: begin
                if (word[1:0] == `TIMER_REG_COMPARE) begin
                    return compare_model;
                end
                return expected; // Count and status depend on cycle timing.
            end
            `PREFIX_GPIO: begin
                case (word[1:0])
                    `GPIO_REG_OUT:    return {16'h0, out_model};
                    `GPIO_REG_IN:     return {16'h0, gpio_in};
                    `GPIO_REG_IRQ_EN: return {16'h0, en_model};
                    default:          return '0;
                endcase
            end
            default:         return '0;
        endcase
    endfunction

    task automatic flag_mismatch(input string what, input soc_bus_pkg::word_t got,
                                 input soc_bus_pkg::word_t want);
        $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    // Sampled mid-cycle when request and response are settled.
    always @(negedge clk) begin
        logic [`PREFIX_WIDTH-1:0] prefix;
        logic [7:0]               word;
        soc_bus_pkg::word_t       merged;
        int                       want_stall;
        prefix = req.address[`ADDRESS_WIDTH-1 -: `PREFIX_WIDTH];
        word   = req.address[2 +: `TARGET_ADDRESS_WIDTH];
        if (rst) begin
            errors        = 0;
            checks        = 0;
            stall_cycles  = 0;
            out_model     = '0;
            en_model      = '0;
            compare_model = '0;
        end else begin
            if (gpio_out !== out_model) begin
                flag_mismatch("gpio_out", {16'h0, gpio_out}, {16'h0, out_model});
            end
            if ((req.read || req.write) && rsp.stall) begin
                stall_cycles++;
            end else if (req.read || req.write) begin
                checks++;
                want_stall = (req.read && prefix == `PREFIX_RAM) ? 1 : 0; // RAM reads wait once.
                if (stall_cycles != want_stall) begin
                    flag_mismatch("stall cycle count", stall_cycles, want_stall);
                end
                stall_cycles = 0;
                if (req.read) begin
                    if (rsp.data_rd !== model_read(prefix, word)) begin
                        flag_mismatch("read data", rsp.data_rd, model_read(prefix, word));
                    end
                    if (check && rsp.data_rd !== expected) begin
                        flag_mismatch("read data against table", rsp.data_rd, expected);
                    end
                end else if (prefix == `PREFIX_RAM) begin
                    ram_model[word] = merge_lanes(ram_model[word], req.data_wr, req.mask);
                end else if (prefix == `PREFIX_GPIO && word[1:0] == `GPIO_REG_OUT) begin
                    merged    = merge_lanes({16'h0, out_model}, req.data_wr, req.mask);
                    out_model = merged[`GPIO_WIDTH-1:0];
                end else if (prefix == `PREFIX_GPIO && word[1:0] == `GPIO_REG_IRQ_EN) begin
                    en_model = req.data_wr[`GPIO_WIDTH-1:0];
                end else if (prefix == `PREFIX_TIMER && word[1:0] == `TIMER_REG_COMPARE) begin
                    compare_model = req.data_wr;
                end
                if (check && interrupt !== exp_irq) begin
                    flag_mismatch("interrupt", {31'b0, interrupt}, {31'b0, exp_irq});
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_macros.svh"

module bus_tb;

    typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE} op_t;

    typedef struct packed {
        op_t                     op;
        soc_bus_pkg::address_t   address;
        soc_bus_pkg::word_t      data;     // Idle cycles for OP_IDLE.
        soc_bus_pkg::byte_mask_t mask;
        soc_bus_pkg::gpio_t      pins;
        soc_bus_pkg::word_t      expected;
        logic                    exp_irq;
        logic                    check;    // Compare read data and interrupt with the table.
    } entry_t;

    logic                  clk;
    logic                  rst;
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t rsp;
    logic                  interrupt;
    soc_bus_pkg::gpio_t    gpio_in;
    soc_bus_pkg::gpio_t    gpio_out;
    soc_bus_pkg::word_t    expected;
    logic                  exp_irq;
    logic                  check;
    int                    errors;
    int                    checks;
    int                    assert_failures;
    int                    cycle_limit = 0;
    int                    seed = 43313;
    entry_t                stimulus [$];

    bus_subsystem i_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rsp       (rsp),
        .interrupt (interrupt),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    bus_monitor i_monitor (.*);

    assign assert_failures = i_dut.i_data_bus.i_bus_checker.failures;

    task automatic add_entry(input op_t op, input logic [3:0] prefix, input int word,
                             input soc_bus_pkg::word_t data, input soc_bus_pkg::byte_mask_t mask,
                             input soc_bus_pkg::gpio_t pins, input soc_bus_pkg::word_t want,
                             input logic want_irq);
        entry_t e;
        e.op       = op;
        e.address  = soc_bus_pkg::address_t'(word * 4);
        e.address[`ADDRESS_WIDTH-1 -: `PREFIX_WIDTH] = prefix;
        e.data     = data;
        e.mask     = mask;
        e.pins     = pins;
        e.expected = want;
        e.exp_irq  = want_irq;
        e.check    = (op == OP_READ) && (prefix != `PREFIX_RAM); // RAM is left to the model.
        stimulus.push_back(e);
    endtask

    // Hold the request until stall drops, then one cycle with no strobe.
    task automatic apply_entry(input entry_t e);
        if (e.op == OP_IDLE) begin
            repeat (e.data) @(posedge clk);
        end else begin
            @(posedge clk);
            req.read    <= (e.op == OP_READ);
            req.write   <= (e.op == OP_WRITE);
            req.address <= e.address;
            req.data_wr <= e.data;
            req.mask    <= e.mask;
            gpio_in     <= e.pins;
            expected    <= e.expected;
            exp_irq     <= e.exp_irq;
            check       <= e.check;
            @(negedge clk);
            while (rsp.stall) begin
                @(negedge clk);
            end
            @(posedge clk);
            req.read  <= 1'b0;
            req.write <= 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the stimulus table did not finish within %0d cycles", cycles);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors + 1, assert_failures);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        req      = '0;
        gpio_in  = '0;
        expected = '0;
        exp_irq  = 1'b0;
        check    = 1'b0;

        add_entry(OP_WRITE, `PREFIX_RAM, 4, $random(seed), 4'hF, '0, '0, 1'b0);
        add_entry(OP_WRITE, `PREFIX_RAM, 4, $random(seed), 4'h5, '0, '0, 1'b0);
        add_entry(OP_WRITE, `PREFIX_RAM, 255, $random(seed), 4'hF, '0, '0, 1'b0);
        add_entry(OP_WRITE, `PREFIX_RAM, 255, $random(seed), 4'h6, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_RAM, 4, '0, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_RAM, 255, '0, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_BOOTROM, 0, '0, 4'hF, '0, 32'hB000_0000, 1'b0);
        add_entry(OP_READ, `PREFIX_BOOTROM, 5, '0, 4'hF, '0, 32'hB005_0019, 1'b0);
        add_entry(OP_READ, `PREFIX_BOOTROM, 63, '0, 4'hF, '0, 32'hB03F_0F81, 1'b0);
        add_entry(OP_WRITE, `PREFIX_BOOTROM, 5, 32'hFFFF_FFFF, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_BOOTROM, 5, '0, 4'hF, '0, 32'hB005_0019, 1'b0);
        add_entry(OP_WRITE, `PREFIX_GPIO, 0, 32'h0000_1234, 4'hF, '0, '0, 1'b0);
        add_entry(OP_WRITE, `PREFIX_GPIO, 0, 32'h0000_AB00, 4'h2, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_GPIO, 0, '0, 4'hF, '0, 32'h0000_AB34, 1'b0);
        add_entry(OP_READ, `PREFIX_GPIO, 1, '0, 4'hF, 16'h0081, 32'h0000_0081, 1'b0);
        add_entry(OP_WRITE, `PREFIX_GPIO, 2, 32'h0000_0001, 4'hF, 16'h0081, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_GPIO, 2, '0, 4'hF, 16'h0081, 32'h0000_0001, 1'b1);
        add_entry(OP_READ, `PREFIX_GPIO, 1, '0, 4'hF, 16'h0080, 32'h0000_0080, 1'b0);
        // Timer fires three counts after enable, status then reads pending and enable.
        add_entry(OP_WRITE, `PREFIX_TIMER, 1, 32'd3, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_TIMER, 1, '0, 4'hF, '0, 32'd3, 1'b0);
        add_entry(OP_WRITE, `PREFIX_TIMER, 2, 32'd1, 4'hF, '0, '0, 1'b0);
        add_entry(OP_IDLE, 4'h0, 0, 32'd3, 4'h0, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_TIMER, 2, '0, 4'hF, '0, 32'd3, 1'b1);
        add_entry(OP_WRITE, `PREFIX_TIMER, 2, 32'd2, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_TIMER, 2, '0, 4'hF, '0, 32'd0, 1'b0);
        add_entry(OP_WRITE, 4'h7, 4, 32'hDEAD_BEEF, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, 4'h7, 4, '0, 4'hF, '0, 32'd0, 1'b0);
        add_entry(OP_READ, `PREFIX_RAM, 4, '0, 4'hF, '0, '0, 1'b0);
        add_entry(OP_READ, `PREFIX_GPIO, 0, '0, 4'hF, '0, 32'h0000_AB34, 1'b0);
        add_entry(OP_READ, 4'hF, 0, '0, 4'hF, '0, 32'd0, 1'b0);
        cycle_limit = 20 * stimulus.size() + 200;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (stimulus[i]) begin
            apply_entry(stimulus[i]);
        end
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/soc_bus_pkg.sv
hw/data_bus.sv
hw/bus_ram.sv
hw/boot_rom.sv
hw/bus_timer.sv
hw/bus_gpio.sv
hw/bus_subsystem.sv
verif/bus_checker.sv
verif/bus_monitor.sv
verif/bus_tb.sv
